/* all.f */
source/fetch_pkg.sv
source/mem_dp.sv
source/icache.sv
source/refill_unit.sv
source/fetch_window.sv
source/fetch_top.sv
tb/fetch_tb.sv

/* run.sh */
#!/bin/sh
# build the fetch front end with its testbench, then run it
# the exit status of the simulation is the result of the run

verilator --binary --assert --top-module fetch_tb -f all.f -o fetch_sim \
    && ./obj_dir/fetch_sim \
    || exit 1

/* source/fetch_pkg.sv */
package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // address layout
    ////////////////////////////////////////////////////////////////////////////

    // 16 bit byte addresses
    localparam int addr_bits = 16;
    // byte offset inside one 64 bit block
    localparam int offset_bits = 3;

    // direct mapped, one block per line
    localparam int icache_lines = 32;
    localparam int index_bits = 5;
    // what is left above index and offset
    localparam int tag_bits = addr_bits - index_bits - offset_bits;

    // blocks read per lookup, fetch block plus lookahead
    localparam int prefetch_distance = 2;

    typedef logic [addr_bits-1:0] addr_t;
    // block number, the address without its offset
    typedef logic [addr_bits-offset_bits-1:0] block_num_t;
    typedef logic [31:0] inst_t;

    ////////////////////////////////////////////////////////////////////////////
    // data carried between blocks
    ////////////////////////////////////////////////////////////////////////////

    // cache line and memory transfer unit
    // word0 sits at the lower address
    typedef struct packed {
        inst_t word0;
        inst_t word1;
    } mem_block_t;

    typedef struct packed {
        logic                valid;
        logic [tag_bits-1:0] tag;
    } icache_tag_t;

    // packet handed to decode
    // slot 1 only valid together with slot 0
    typedef struct packed {
        addr_t       pc;
        inst_t [1:0] slot;
        logic  [1:0] slot_valid;
    } fetch_packet_t;

    // memory side four-phase handshake
    typedef enum logic [1:0] {
        refill_idle,
        refill_request,
        refill_release
    } refill_state_t;

    // decoder side four-phase handshake
    typedef enum logic [1:0] {
        handoff_idle,
        handoff_offer,
        handoff_release
    } handoff_state_t;

endpackage

/* source/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic          clock,
    input  logic          reset,

    input  logic          redirect_valid,
    input  addr_t         redirect_pc,

    // memory side
    output logic          mem_req,
    output addr_t         mem_addr,
    input  logic          mem_ack,
    input  mem_block_t    mem_data,

    // decoder side
    output logic          out_req,
    input  logic          out_ack,
    output fetch_packet_t out_packet
);

    addr_t                              fetch_pc;
    mem_block_t [prefetch_distance-1:0] blocks;
    logic       [prefetch_distance-1:0] hits;

    logic       fill_en;
    addr_t      fill_addr;
    mem_block_t fill_data;

    ////////////////////////////////////////////////////////////////////////////
    // lookup, refill, handoff
    ////////////////////////////////////////////////////////////////////////////

    icache i_icache (
        .clock     (clock),
        .reset     (reset),
        .fetch_pc  (fetch_pc),
        .fill_en   (fill_en),
        .fill_addr (fill_addr),
        .fill_data (fill_data),
        .blocks    (blocks),
        .hits      (hits)
    );

    refill_unit i_refill_unit (
        .clock     (clock),
        .reset     (reset),
        .fetch_pc  (fetch_pc),
        .hits      (hits),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_data  (mem_data),
        .fill_en   (fill_en),
        .fill_addr (fill_addr),
        .fill_data (fill_data)
    );

    fetch_window i_fetch_window (
        .clock          (clock),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .blocks         (blocks),
        .hits           (hits),
        .fetch_pc       (fetch_pc),
        .out_req        (out_req),
        .out_ack        (out_ack),
        .out_packet     (out_packet)
    );

endmodule

/* source/fetch_window.sv */
`timescale 1ns/10ps

module fetch_window
    import fetch_pkg::*;
(
    input  logic                                clock,
    input  logic                                reset,

    input  logic                                redirect_valid,
    input  addr_t                               redirect_pc,

    // lookup result for fetch_pc
    input  mem_block_t [prefetch_distance-1:0]  blocks,
    input  logic       [prefetch_distance-1:0]  hits,
    output addr_t                               fetch_pc,

    // decoder handshake
    output logic                                out_req,
    input  logic                                out_ack,
    output fetch_packet_t                       out_packet
);

    handoff_state_t state;
    addr_t          pc;
    logic           redirect_pending;
    addr_t          redirect_target;

    fetch_packet_t  next_packet;
    logic           take_redirect;
    addr_t          new_pc;
    logic           start_offer;
    addr_t          pc_step;

    assign fetch_pc = pc;

    ////////////////////////////////////////////////////////////////////////////
    // packet build
    ////////////////////////////////////////////////////////////////////////////

    // pc bit 2 picks the word inside block 0
    always_comb begin
        next_packet.pc = pc;
        if (!pc[2]) begin
            next_packet.slot[0]    = blocks[0].word0;
            next_packet.slot[1]    = blocks[0].word1;
            next_packet.slot_valid = 2'b11;
        end else begin
            // second word comes from the lookahead block
            next_packet.slot[0]    = blocks[0].word1;
            next_packet.slot[1]    = blocks[1].word0;
            next_packet.slot_valid = {hits[1], 1'b1};
        end
    end

    // a pulse this cycle beats one already pending
    assign take_redirect = redirect_valid || redirect_pending;
    assign new_pc        = redirect_valid ? redirect_pc : redirect_target;
    assign start_offer   = (state == handoff_idle) && !take_redirect && hits[0];

    // four bytes per valid slot
    assign pc_step = out_packet.slot_valid[1] ? addr_t'(8) : addr_t'(4);

    ////////////////////////////////////////////////////////////////////////////
    // handoff FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state            <= handoff_idle;
            pc               <= '0;
            out_req          <= 1'b0;
            redirect_pending <= 1'b0;
        end else begin
            if (redirect_valid) begin
                redirect_pending <= 1'b1;
            end
            case (state)
                handoff_idle: begin
                    if (take_redirect) begin
                        pc               <= new_pc;
                        redirect_pending <= 1'b0;
                    end else if (start_offer) begin
                        out_req <= 1'b1;
                        state   <= handoff_offer;
                    end
                end
                handoff_offer: begin
                    // packet stays put, redirect waits
                    if (out_ack) begin
                        out_req <= 1'b0;
                        pc      <= pc + pc_step;
                        state   <= handoff_release;
                    end
                end
                handoff_release: begin
                    if (!out_ack) begin
                        state <= handoff_idle;
                    end
                end
                default: state <= handoff_idle;
            endcase
        end
    end

    // redirect target and offered packet
    always_ff @(posedge clock) begin
        if (redirect_valid) begin
            redirect_target <= redirect_pc;
        end
        if (start_offer) begin
            out_packet <= next_packet;
        end
    end

    // offered packet never changes under the decoder
    packet_stable: assert property (
        @(posedge clock) disable iff (reset)
        (out_req && $past(out_req)) |-> $stable(out_packet)
    );

endmodule

/* source/icache.sv */
`timescale 1ns/10ps

module icache
    import fetch_pkg::*;
(
    input  logic                                   clock,
    input  logic                                   reset,

    // lookup address from the fetch window
    input  addr_t                                  fetch_pc,

    // fill port from the refill unit
    input  logic                                   fill_en,
    input  addr_t                                  fill_addr,
    input  mem_block_t                             fill_data,

    // fetch block and lookahead blocks
    output mem_block_t [prefetch_distance-1:0]     blocks,
    output logic       [prefetch_distance-1:0]     hits
);

    ////////////////////////////////////////////////////////////////////////////
    // address split
    ////////////////////////////////////////////////////////////////////////////

    block_num_t                                     fetch_block;
    block_num_t [prefetch_distance-1:0]             look_block;
    logic       [prefetch_distance-1:0][index_bits-1:0] look_index;
    logic       [prefetch_distance-1:0][tag_bits-1:0]   look_tag;
    logic       [prefetch_distance-1:0][$bits(mem_block_t)-1:0] line_data;

    logic [index_bits-1:0] fill_index;
    logic [tag_bits-1:0]   fill_tag;

    // one tag entry per line
    icache_tag_t tags [icache_lines];

    // drop the byte offset, keep tag and index together
    assign fetch_block = fetch_pc[addr_bits-1:offset_bits];

    // block i is simply the block number plus i
    // index wraps, the carry lands in the tag
    always_comb begin
        for (int i = 0; i < prefetch_distance; i++) begin
            look_block[i] = fetch_block + block_num_t'(i);
            look_index[i] = look_block[i][index_bits-1:0];
            look_tag[i]   = look_block[i][index_bits +: tag_bits];
        end
    end

    // fill goes by its own address
    assign fill_index = fill_addr[offset_bits +: index_bits];
    assign fill_tag   = fill_addr[offset_bits+index_bits +: tag_bits];

    ////////////////////////////////////////////////////////////////////////////
    // data array
    ////////////////////////////////////////////////////////////////////////////

    mem_dp #(
        .width      ($bits(mem_block_t)),
        .depth      (icache_lines),
        .read_ports (prefetch_distance)
    ) i_data_mem (
        .clock (clock),
        .reset (reset),
        .re    ('1),
        .raddr (look_index),
        .rdata (line_data),
        .we    (fill_en),
        .waddr (fill_index),
        .wdata (fill_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // tag compare
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < prefetch_distance; i++) begin
            blocks[i] = line_data[i];
            hits[i]   = tags[look_index[i]].valid && (tags[look_index[i]].tag == look_tag[i]);
        end
    end

    // tag written with the data, same edge
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < icache_lines; i++) begin
                tags[i] <= '0;
            end
        end else if (fill_en) begin
            tags[fill_index] <= '{valid: 1'b1, tag: fill_tag};
        end
    end

    // filling the fetch block with pc held gives a hit next cycle
    fill_then_hit: assert property (
        @(posedge clock) disable iff (reset)
        (fill_en && (fill_addr[addr_bits-1:offset_bits] == fetch_block)) ##1
            $stable(fetch_pc) |-> hits[0]
    );

endmodule

/* source/mem_dp.sv */
`timescale 1ns/10ps

module mem_dp #(
    parameter int width      = 64,
    parameter int depth      = 32,
    parameter int read_ports = 2,
    parameter int addr_bits  = $clog2(depth)
) (
    input  logic                                 clock,
    input  logic                                 reset,

    // read side, one enable and address per port
    input  logic [read_ports-1:0]                re,
    input  logic [read_ports-1:0][addr_bits-1:0] raddr,
    output logic [read_ports-1:0][width-1:0]     rdata,

    // single write port
    input  logic                                 we,
    input  logic [addr_bits-1:0]                 waddr,
    input  logic [width-1:0]                     wdata
);

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    logic [width-1:0] mem [depth];

    ////////////////////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////////////////////

    // combinational, no bypass from the write port
    // a write is seen on the cycle after its edge
    always_comb begin
        for (int i = 0; i < read_ports; i++) begin
            if (re[i]) begin
                rdata[i] = mem[raddr[i]];
            end else begin
                // disabled port reads as zero
                rdata[i] = '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // whole array back to zero
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

/* source/refill_unit.sv */
`timescale 1ns/10ps

module refill_unit
    import fetch_pkg::*;
(
    input  logic                           clock,
    input  logic                           reset,

    // lookup state from the fetch side
    input  addr_t                          fetch_pc,
    input  logic [prefetch_distance-1:0]   hits,

    // memory handshake
    output logic                           mem_req,
    output addr_t                          mem_addr,
    input  logic                           mem_ack,
    input  mem_block_t                     mem_data,

    // cache write port
    output logic                           fill_en,
    output addr_t                          fill_addr,
    output mem_block_t                     fill_data
);

    refill_state_t state;

    logic       miss;
    block_num_t miss_block;

    ////////////////////////////////////////////////////////////////////////////
    // miss select
    ////////////////////////////////////////////////////////////////////////////

    // walk from the far end down, so the lowest missing block wins
    always_comb begin
        miss       = 1'b0;
        miss_block = fetch_pc[addr_bits-1:offset_bits];
        for (int i = prefetch_distance - 1; i >= 0; i--) begin
            if (!hits[i]) begin
                miss       = 1'b1;
                miss_block = fetch_pc[addr_bits-1:offset_bits] + block_num_t'(i);
            end
        end
    end

    // the fill goes where the request went
    assign fill_addr = mem_addr;

    ////////////////////////////////////////////////////////////////////////////
    // handshake FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= refill_idle;
            mem_req <= 1'b0;
            fill_en <= 1'b0;
        end else begin
            // fill is a single cycle pulse
            fill_en <= 1'b0;
            case (state)
                refill_idle: begin
                    if (miss) begin
                        mem_req <= 1'b1;
                        state   <= refill_request;
                    end
                end
                refill_request: begin
                    // data valid with ack, write it and let go of req
                    // held even if the pc has moved on
                    if (mem_ack) begin
                        fill_en <= 1'b1;
                        mem_req <= 1'b0;
                        state   <= refill_release;
                    end
                end
                refill_release: begin
                    // wait out the ack before the next request
                    if (!mem_ack) begin
                        state <= refill_idle;
                    end
                end
                default: state <= refill_idle;
            endcase
        end
    end

    // address latched as req rises, data as ack is seen
    always_ff @(posedge clock) begin
        if (state == refill_idle && miss) begin
            mem_addr <= {miss_block, {offset_bits{1'b0}}};
        end
        if (state == refill_request && mem_ack) begin
            fill_data <= mem_data;
        end
    end

    // req only drops once memory has answered
    req_falls_after_ack: assert property (
        @(posedge clock) disable iff (reset)
        $fell(mem_req) |-> $past(mem_ack)
    );

    // no new req while the previous ack is still up
    req_rises_after_release: assert property (
        @(posedge clock) disable iff (reset)
        $rose(mem_req) |-> !$past(mem_ack)
    );

endmodule

/* tb/fetch_stimulus.txt */
# redirect_pc packets mem_ack_delay dec_ack_delay
# redirect_pc in hex, the other columns in decimal
0040 6 2 1
0084 5 3 2
0040 4 0 1
00a0 4 1 9
0010 3 4 6
0044 3 0 0
00c0 2 2 12

/* tb/fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb
    import fetch_pkg::*;
;

    logic          clock;
    logic          reset;
    logic          redirect_valid;
    addr_t         redirect_pc;
    logic          mem_req;
    addr_t         mem_addr;
    logic          mem_ack;
    mem_block_t    mem_data;
    logic          out_req;
    logic          out_ack;
    fetch_packet_t out_packet;

    // segments from the stimulus file
    addr_t seg_pc [$];
    int    seg_count [$];
    int    seg_mem_delay [$];
    int    seg_dec_delay [$];
    int    cur_mem_delay;
    int    cur_dec_delay;

    // run length and timeout
    int cycle;
    int cycle_limit;

    // cache model, one entry per line
    logic       line_valid [icache_lines];
    block_num_t line_blk [icache_lines];
    int         line_cyc [icache_lines];

    // request log and handshake history
    addr_t req_addr_q [$];
    int    req_cyc_q [$];
    int    out_rise;
    logic  mem_req_q;
    logic  out_req_q;

    fetch_top i_fetch_top (
        .clock          (clock),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_ack        (mem_ack),
        .mem_data       (mem_data),
        .out_req        (out_req),
        .out_ack        (out_ack),
        .out_packet     (out_packet)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    // memory contents, each word is its byte address xor a fixed pattern
    function automatic inst_t rule_word(input addr_t a);
        return {16'h0000, a} ^ 32'h1357_9bdf;
    endfunction

    function automatic logic cached(input block_num_t b);
        return line_valid[b[index_bits-1:0]] && (line_blk[b[index_bits-1:0]] == b);
    endfunction

    // a fill reaches the packet only if hits showed it before the offer edge
    function automatic logic model_hit(input block_num_t b, input int rise);
        return cached(b) && (line_cyc[b[index_bits-1:0]] + 2 <= rise);
    endfunction

    task automatic check_packet(input fetch_packet_t got, input fetch_packet_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch out_packet: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_mem_addr(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch mem_addr: got %h expected %h", got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus file
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int    fd;
        int    n;
        string line;
        int    pc_val;
        int    cnt;
        int    md;
        int    dd;
        fd = $fopen("tb/fetch_stimulus.txt", "r");
        if (fd == 0) begin
            fail_now("could not open the stimulus file");
        end
        cycle_limit = 8;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // skip comments and blank lines
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %d %d %d", pc_val, cnt, md, dd);
                if (n == 4) begin
                    seg_pc.push_back(addr_t'(pc_val));
                    seg_count.push_back(cnt);
                    seg_mem_delay.push_back(md);
                    seg_dec_delay.push_back(dd);
                    cycle_limit = cycle_limit + 200 * (1 + md + dd);
                end
            end
        end
        $fclose(fd);
    end

    // timeout
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle > cycle_limit) begin
            fail_now("timeout, the fetch front end stopped making progress");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // port monitor, sampled away from the rising edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset) begin
            if (mem_req && !mem_req_q) begin
                if (mem_ack) begin
                    fail_now("mem_req rose while mem_ack was still high");
                end
                if (cached(mem_addr[addr_bits-1:offset_bits])) begin
                    fail_now("memory request for a block already in the cache");
                end
                req_addr_q.push_back(mem_addr);
                req_cyc_q.push_back(cycle);
            end
            if (!mem_req && mem_req_q) begin
                if (!mem_ack) begin
                    fail_now("mem_req fell before mem_ack rose");
                end
                // block written at the edge after req fell
                line_valid[mem_addr[offset_bits +: index_bits]] = 1'b1;
                line_blk[mem_addr[offset_bits +: index_bits]] =
                    mem_addr[addr_bits-1:offset_bits];
                line_cyc[mem_addr[offset_bits +: index_bits]] = cycle;
            end
            if (out_req && !out_req_q) begin
                if (out_ack) begin
                    fail_now("out_req rose while out_ack was still high");
                end
                out_rise = cycle;
            end
            if (!out_req && out_req_q && !out_ack) begin
                fail_now("out_req fell before out_ack rose");
            end
        end
        mem_req_q = mem_req;
        out_req_q = out_req;
    end

    // memory responder
    initial begin
        int wait_cycles;
        void'($urandom(32'h59a8_629b));
        forever begin
            do @(posedge clock); while (!mem_req);
            wait_cycles = cur_mem_delay + int'($urandom % 4);
            repeat (wait_cycles) @(posedge clock);
            mem_data <= '{word0: rule_word(mem_addr), word1: rule_word(mem_addr + addr_t'(4))};
            mem_ack  <= 1'b1;
            do @(posedge clock); while (mem_req);
            mem_ack  <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // decoder model
    ////////////////////////////////////////////////////////////////////////////

    // takes one packet, checks it while held, returns the pc step
    task automatic take_packet(input addr_t pc_exp, output addr_t step);
        fetch_packet_t exp;
        do @(posedge clock); while (!out_req);
        exp.pc         = pc_exp;
        exp.slot[0]    = rule_word(pc_exp);
        exp.slot[1]    = rule_word(pc_exp + addr_t'(4));
        exp.slot_valid = 2'b01;
        if (!pc_exp[2] || model_hit(pc_exp[addr_bits-1:offset_bits] + block_num_t'(1),
                                     out_rise)) begin
            exp.slot_valid = 2'b11;
        end else begin
            // invalid slot carries no defined word
            exp.slot[1] = out_packet.slot[1];
        end
        check_packet(out_packet, exp);
        repeat (cur_dec_delay) begin
            @(posedge clock);
            check_packet(out_packet, exp);
        end
        out_ack <= 1'b1;
        do @(posedge clock); while (out_req);
        out_ack <= 1'b0;
        step = exp.slot_valid[1] ? addr_t'(8) : addr_t'(4);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        addr_t model_pc;
        addr_t step;
        logic  cold;
        int    k;
        reset          = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        mem_ack        = 1'b0;
        mem_data       = '0;
        out_ack        = 1'b0;
        cycle          = 0;
        cur_mem_delay  = 0;
        cur_dec_delay  = 0;
        out_rise       = 0;
        mem_req_q      = 1'b0;
        out_req_q      = 1'b0;
        for (int i = 0; i < icache_lines; i++) begin
            line_valid[i] = 1'b0;
            line_blk[i]   = '0;
            line_cyc[i]   = 0;
        end
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        // pc comes out of reset at zero
        model_pc = '0;
        for (int s = 0; s < seg_pc.size(); s++) begin
            cur_mem_delay = seg_mem_delay[s];
            cur_dec_delay = seg_dec_delay[s];
            // redirect pulsed while the old stream has a packet on offer
            do @(posedge clock); while (!out_req);
            redirect_pc    <= seg_pc[s];
            redirect_valid <= 1'b1;
            @(posedge clock);
            redirect_valid <= 1'b0;
            // the packet on offer still belongs to the old pc
            take_packet(model_pc, step);
            cold = !cached(seg_pc[s][addr_bits-1:offset_bits]);
            model_pc = seg_pc[s];
            for (k = 0; k < seg_count[s]; k++) begin
                take_packet(model_pc, step);
                if (k == 0 && cold) begin
                    // last request before the offer filled block 0
                    for (int r = req_addr_q.size() - 1; r >= 0; r--) begin
                        if (req_cyc_q[r] < out_rise) begin
                            check_mem_addr(req_addr_q[r],
                                           {seg_pc[s][addr_bits-1:offset_bits], 3'b000});
                            break;
                        end
                    end
                end
                model_pc = model_pc + step;
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule
